//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := mpu_tb
FILELIST := project.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- dv/mpu_model.svh
`ifndef MPU_MODEL_SVH
`define MPU_MODEL_SVH

// Map table and thread memory as the host sees them
logic				m_valid [mpu_pkg::THREAD_NUM];
int					m_base  [mpu_pkg::THREAD_NUM];
int					m_len   [mpu_pkg::THREAD_NUM];
mpu_pkg::instr_t	m_mem   [mpu_pkg::MEM_DEPTH];
int					m_alloc;

mpu_pkg::issue_no_t	m_next_no;
mpu_pkg::issue_no_t	m_oldest;
int					m_outstanding;
int					m_credits;		// Credits the lane still holds

// Words the lane should see, in order
mpu_pkg::instr_t	exp_instr [$];
mpu_pkg::issue_no_t	exp_no    [$];
logic				exp_last  [$];

task automatic model_reset();
	foreach (m_valid[i])
		m_valid[i] = 1'b0;
	m_alloc       = 0;
	m_next_no     = '0;
	m_oldest      = '0;
	m_outstanding = 0;
	m_credits     = mpu_pkg::CREDIT_MAX;
endtask

// Bump allocation, no reuse
function automatic logic header_fits(int len);
	return (len != 0) && (m_alloc + len <= mpu_pkg::MEM_DEPTH);
endfunction

//////////////////////////////////////////////////
// Compare tasks
task automatic check_instr(mpu_pkg::instr_t got, mpu_pkg::instr_t exp, string what);
	if (got !== exp)
		report_failure($sformatf("FAIL at %0t: %s is %h, expected %h", $time, what, got, exp));
endtask

task automatic check_issue_no(mpu_pkg::issue_no_t got, mpu_pkg::issue_no_t exp, string what);
	if (got !== exp)
		report_failure($sformatf("FAIL at %0t: %s is %0d, expected %0d", $time, what, got, exp));
endtask

task automatic check_flag(logic got, logic exp, string what);
	if (got !== exp)
		report_failure($sformatf("FAIL at %0t: %s is %b, expected %b", $time, what, got, exp));
endtask

`endif

//--- dv/mpu_tb.sv
`timescale 1ns/1ps

module mpu_tb;

	localparam int NUM_OPS        = 47;			// Loads, issues and commits
	localparam int TIMEOUT_CYCLES = NUM_OPS * 80;

	logic				clock = 1'b0;
	logic				rst;
	logic				load_valid;
	mpu_pkg::instr_t	load_data;
	logic				load_err;
	logic				issue_valid;
	mpu_pkg::id_t		issue_id;
	logic				issue_ready;
	logic				issue_err;
	logic				out_valid;
	mpu_pkg::instr_t	out_instr;
	mpu_pkg::issue_no_t	out_issue_no;
	logic				out_last;
	logic				credit_return = 1'b0;
	logic				commit_valid;
	mpu_pkg::issue_no_t	commit_no;
	logic				commit_err;
	logic				commit_full;

	logic				hold_credits;
	int					cycles = 0;
	int					ret_due [$];		// Cycles left before each credit goes back

	`include "mpu_model.svh"

	mpu_top u_dut (.*);

	always #4 clock = ~clock;

	task automatic report_failure(string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	//////////////////////////////////////////////////
	// Lane model and timeout
	task automatic lane_step();
		credit_return = 1'b0;
		foreach (ret_due[i])
			if (ret_due[i] > 0)
				ret_due[i]--;
		if (out_valid) begin
			if (exp_instr.size() == 0)
				report_failure("The lane got a word that no issue asked for");
			check_instr(out_instr, exp_instr.pop_front(), "out_instr");
			check_issue_no(out_issue_no, exp_no.pop_front(), "out_issue_no");
			check_flag(out_last, exp_last.pop_front(), "out_last");
			m_credits--;
			if (m_credits < 0)
				report_failure("The lane got more words than it held credits for");
			ret_due.push_back($urandom_range(5, 0));
		end
		if (!hold_credits && ret_due.size() > 0 && ret_due[0] == 0) begin
			void'(ret_due.pop_front());
			credit_return = 1'b1;
			m_credits++;
		end
	endtask

	always @(negedge clock) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
			report_failure($sformatf("Timeout after %0d cycles with the run unfinished", cycles));
		lane_step();
	end

	//////////////////////////////////////////////////
	// Host side
	task automatic load_thread(mpu_pkg::id_t id, int len);
		logic ok;
		mpu_pkg::instr_t word;
		ok = header_fits(len);
		load_valid = 1'b1;
		load_data  = '0;
		load_data[mpu_pkg::HDR_ID_LSB +: 3]  = id;
		load_data[mpu_pkg::HDR_LEN_LSB +: 7] = 7'(len);
		@(negedge clock);
		check_flag(load_err, !ok, "load_err after header");
		for (int i = 0; i < len; i++) begin
			word      = $urandom;
			load_data = word;
			if (ok)
				m_mem[m_alloc + i] = word;
			@(negedge clock);
			check_flag(load_err, 1'b0, "load_err on body word");
		end
		load_valid = 1'b0;
		if (ok) begin
			m_valid[id] = 1'b1;		// Reload just moves the entry
			m_base[id]  = m_alloc;
			m_len[id]   = len;
			m_alloc += len;
		end
	endtask

	task automatic issue_thread(mpu_pkg::id_t id);
		logic hit;
		hit = m_valid[id];
		while (!issue_ready)
			@(negedge clock);
		for (int i = 0; hit && i < m_len[id]; i++) begin
			exp_instr.push_back(m_mem[m_base[id] + i]);
			exp_no.push_back(m_next_no);
			exp_last.push_back(i == m_len[id] - 1);
		end
		issue_valid = 1'b1;
		issue_id    = id;
		@(negedge clock);
		issue_valid = 1'b0;
		check_flag(issue_err, !hit, "issue_err");
		if (hit) begin
			m_next_no++;
			m_outstanding++;
		end
	endtask

	task automatic wait_words();
		while (exp_instr.size() != 0)
			@(negedge clock);
		check_flag(commit_full, m_outstanding == mpu_pkg::MAX_OUTSTANDING, "commit_full");
	endtask

	task automatic commit_issue(mpu_pkg::issue_no_t no);
		logic ok;
		ok = (m_outstanding > 0) && (no == m_oldest);
		commit_valid = 1'b1;
		commit_no    = no;
		@(negedge clock);
		commit_valid = 1'b0;
		check_flag(commit_err, !ok, "commit_err");
		if (ok) begin
			m_oldest++;
			m_outstanding--;
		end
		check_flag(commit_full, m_outstanding == mpu_pkg::MAX_OUTSTANDING, "commit_full");
	endtask

	task automatic check_full_stall();
		repeat (4) begin
			check_flag(issue_ready, 1'b0, "issue_ready while full");
			@(negedge clock);
		end
		commit_issue(m_oldest + 1'b1);		// Out of order
		check_flag(issue_ready, 1'b0, "issue_ready after wrong commit");
		commit_issue(m_oldest);
		check_flag(issue_ready, 1'b1, "issue_ready after commit");
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	initial begin
		int issued;
		mpu_pkg::id_t spare;
		mpu_pkg::id_t again;
		void'($urandom(32'h1191));
		rst          = 1'b1;
		load_valid   = 1'b0;
		load_data    = '0;
		issue_valid  = 1'b0;
		issue_id     = '0;
		commit_valid = 1'b0;
		commit_no    = '0;
		hold_credits = 1'b0;
		issued       = 0;
		model_reset();
		repeat (8) @(negedge clock);
		rst = 1'b0;
		@(negedge clock);
		check_flag(out_valid, 1'b0, "out_valid after reset");
		check_flag(issue_ready, 1'b1, "issue_ready after reset");
		check_flag(commit_full, 1'b0, "commit_full after reset");
		check_flag(load_err, 1'b0, "load_err after reset");
		check_flag(issue_err, 1'b0, "issue_err after reset");
		check_flag(commit_err, 1'b0, "commit_err after reset");

		for (int t = 0; t < 4; t++)
			load_thread(3'($urandom), $urandom_range(12, 1));
		load_thread(3'($urandom), 0);
		for (int i = mpu_pkg::THREAD_NUM - 1; i >= 0; i--)
			if (!m_valid[i])
				spare = 3'(i);
		issue_thread(spare);			// Never loaded

		// Enough issues to wrap the issue number
		while (issued < 12) begin
			for (int i = 0; i < mpu_pkg::THREAD_NUM; i++) begin
				if (m_valid[i] && issued < 12) begin
					issue_thread(3'(i));
					wait_words();
					issued++;
					if (m_outstanding == mpu_pkg::MAX_OUTSTANDING)
						check_full_stall();
				end
			end
		end
		while (m_outstanding > 0)
			commit_issue(m_oldest);
		commit_issue(m_oldest);			// Nothing outstanding

		// Reload, overflow, then a header that still fits
		for (int i = mpu_pkg::THREAD_NUM - 1; i >= 0; i--)
			if (m_valid[i])
				again = 3'(i);
		load_thread(again, $urandom_range(12, 5));
		load_thread(3'($urandom), mpu_pkg::MEM_DEPTH - m_alloc + 1 + $urandom_range(3, 0));
		load_thread(spare, $urandom_range(mpu_pkg::MEM_DEPTH - m_alloc, 1));
		issue_thread(spare);
		wait_words();

		// Withheld credits stall the reloaded thread
		while (ret_due.size() != 0)
			@(negedge clock);
		hold_credits = 1'b1;
		issue_thread(again);
		repeat (20) @(negedge clock);
		check_flag(exp_instr.size() == m_len[again] - mpu_pkg::CREDIT_MAX, 1'b1,
			"words left after credits ran out");
		hold_credits = 1'b0;
		wait_words();
		while (m_outstanding > 0)
			commit_issue(m_oldest);

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- logic/commit_tracker.sv
`timescale 1ns/1ps

module commit_tracker (
	input	logic					clock,
	input	logic					rst,
	input	logic					issue,
	output	mpu_pkg::issue_no_t		next_no,
	input	logic					commit_valid,
	input	mpu_pkg::issue_no_t		commit_no,
	output	logic					commit_err,
	output	logic					full
);

	mpu_pkg::issue_no_t		oldest;			// Oldest uncommitted number
	mpu_pkg::out_cnt_t		outstanding;
	logic					commit_ok;

	// In-order commit only
	assign commit_ok = commit_valid && (outstanding != '0) && (commit_no == oldest);
	assign full      = (outstanding == mpu_pkg::out_cnt_t'(mpu_pkg::MAX_OUTSTANDING));

	// Issue and commit pointers, both wrap
	always_ff @(posedge clock) begin
		if (rst) begin
			next_no    <= '0;
			oldest     <= '0;
			commit_err <= 1'b0;
		end else begin
			commit_err <= commit_valid && !commit_ok;
			if (issue)
				next_no <= next_no + 1'b1;
			if (commit_ok)
				oldest <= oldest + 1'b1;
		end
	end

	// Outstanding count
	always_ff @(posedge clock) begin
		if (rst) begin
			outstanding <= '0;
		end else begin
			case ({issue, commit_ok})
				2'b10: outstanding <= outstanding + 1'b1;
				2'b01: outstanding <= outstanding - 1'b1;
				default: outstanding <= outstanding;
			endcase
		end
	end

	// Dispatcher holds off new issues once all slots are taken
	a_no_issue_full: assert property (@(posedge clock) disable iff (rst)
		full |-> !issue);

endmodule

//--- logic/dispatch_fsm.sv
`timescale 1ns/1ps

module dispatch_fsm (
	input	logic					clock,
	input	logic					rst,
	input	logic					issue_valid,
	input	mpu_pkg::id_t			issue_id,
	output	logic					issue_ready,
	output	logic					issue_err,
	input	logic					full,
	input	mpu_pkg::issue_no_t		issue_no,
	output	logic					issue,
	thread_rd_if.dispatch			rd,
	output	logic					out_valid,
	output	mpu_pkg::instr_t		out_instr,
	output	mpu_pkg::issue_no_t		out_issue_no,
	output	logic					out_last,
	input	logic					credit_return
);

	mpu_pkg::dispatch_state_e	state;
	mpu_pkg::id_t				req_id;
	mpu_pkg::issue_no_t			cur_no;
	mpu_pkg::addr_t				rd_ptr;
	mpu_pkg::len_t				left;			// Reads still to launch
	mpu_pkg::credit_t			credits;
	logic						accept;
	logic						hit;
	logic						launch;

	assign issue_ready = (state == mpu_pkg::IDLE) && !full;
	assign accept      = issue_valid && issue_ready;

	// Lookup result checked in LOOKUP
	assign rd.lookup_id = req_id;
	assign hit          = rd.lookup_entry.valid;
	assign issue        = (state == mpu_pkg::LOOKUP) && hit;
	assign issue_err    = (state == mpu_pkg::LOOKUP) && !hit;

	// One read per cycle while credit remains
	assign launch     = (state == mpu_pkg::SEND) && (credits != '0);
	assign rd.rd_en   = launch;
	assign rd.rd_addr = rd_ptr;

	assign out_instr    = rd.rd_data;
	assign out_issue_no = cur_no;

	//////////////////////////////////////////////////
	// Dispatch FSM
	always_ff @(posedge clock) begin
		if (rst) begin
			state     <= mpu_pkg::IDLE;
			rd_ptr    <= '0;
			left      <= '0;
			out_valid <= 1'b0;
			out_last  <= 1'b0;
		end else begin
			out_valid <= launch;						// Word follows its read by one cycle
			out_last  <= launch && (left == 7'd1);
			case (state)
				mpu_pkg::IDLE: begin
					if (accept)
						state <= mpu_pkg::LOOKUP;
				end
				mpu_pkg::LOOKUP: begin
					rd_ptr <= rd.lookup_entry.base;
					left   <= rd.lookup_entry.len;
					state  <= hit ? mpu_pkg::SEND : mpu_pkg::IDLE;
				end
				mpu_pkg::SEND: if (launch) begin
					rd_ptr <= rd_ptr + 1'b1;
					left   <= left - 1'b1;
					if (left == 7'd1)
						state <= mpu_pkg::DRAIN;
				end
				mpu_pkg::DRAIN: state <= mpu_pkg::IDLE;	// Last word on the output
				default: state <= mpu_pkg::IDLE;
			endcase
		end
	end

	// Request ID and issue number
	always_ff @(posedge clock) begin
		if (accept)
			req_id <= issue_id;
		if (issue)
			cur_no <= issue_no;
	end

	//////////////////////////////////////////////////
	// Credit counter
	always_ff @(posedge clock) begin
		if (rst) begin
			credits <= mpu_pkg::credit_t'(mpu_pkg::CREDIT_MAX);
		end else begin
			case ({credit_return, launch})
				2'b10: credits <= credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				default: credits <= credits;		// None, or return and launch cancel
			endcase
		end
	end

	// The lane never returns more than it was given
	a_credit_max: assert property (@(posedge clock) disable iff (rst)
		credits <= mpu_pkg::credit_t'(mpu_pkg::CREDIT_MAX));

endmodule

//--- logic/mpu_pkg.sv
package mpu_pkg;

	//////////////////////////////////////////////////
	// Sizes
	localparam int THREAD_NUM      = 8;
	localparam int MEM_DEPTH       = 64;
	localparam int MAX_OUTSTANDING = 4;
	localparam int CREDIT_MAX      = 4;

	// Counter widths, sized so the maximum value itself fits
	localparam int OUT_W    = $clog2(MAX_OUTSTANDING + 1);
	localparam int CREDIT_W = $clog2(CREDIT_MAX + 1);

	// Header word fields
	localparam int HDR_ID_LSB  = 0;		// ID in bits 2..0
	localparam int HDR_LEN_LSB = 8;		// Length in bits 14..8

	//////////////////////////////////////////////////
	// Types
	typedef logic [2:0]          id_t;
	typedef logic [5:0]          addr_t;
	typedef logic [6:0]          len_t;	// Holds 64
	typedef logic [31:0]         instr_t;
	typedef logic [2:0]          issue_no_t;
	typedef logic [OUT_W-1:0]    out_cnt_t;
	typedef logic [CREDIT_W-1:0] credit_t;

	typedef struct packed {
		logic  valid;
		addr_t base;
		len_t  len;
	} map_entry_t;

	typedef enum logic [1:0] {
		HEADER,
		BODY,
		SKIP
	} loader_state_e;

	typedef enum logic [1:0] {
		IDLE,
		LOOKUP,
		SEND,
		DRAIN
	} dispatch_state_e;

endpackage

//--- logic/mpu_top.sv
`timescale 1ns/1ps

module mpu_top (
	input	logic					clock,
	input	logic					rst,
	// Host load
	input	logic					load_valid,
	input	mpu_pkg::instr_t		load_data,
	output	logic					load_err,
	// Host issue
	input	logic					issue_valid,
	input	mpu_pkg::id_t			issue_id,
	output	logic					issue_ready,
	output	logic					issue_err,
	// Lane
	output	logic					out_valid,
	output	mpu_pkg::instr_t		out_instr,
	output	mpu_pkg::issue_no_t		out_issue_no,
	output	logic					out_last,
	input	logic					credit_return,
	// Host commit
	input	logic					commit_valid,
	input	mpu_pkg::issue_no_t		commit_no,
	output	logic					commit_err,
	output	logic					commit_full
);

	logic					issue_strobe;
	mpu_pkg::issue_no_t		next_no;

	thread_wr_if u_wr_if ();
	thread_rd_if u_rd_if ();

	//////////////////////////////////////////////////
	// Load side
	thread_loader u_loader (
		.clock			(clock),
		.rst			(rst),
		.load_valid		(load_valid),
		.load_data		(load_data),
		.load_err		(load_err),
		.wr				(u_wr_if.loader)
	);

	thread_mem u_mem (
		.clock			(clock),
		.rst			(rst),
		.wr				(u_wr_if.mem),
		.rd				(u_rd_if.mem)
	);

	//////////////////////////////////////////////////
	// Issue side
	dispatch_fsm u_dispatch (
		.clock			(clock),
		.rst			(rst),
		.issue_valid	(issue_valid),
		.issue_id		(issue_id),
		.issue_ready	(issue_ready),
		.issue_err		(issue_err),
		.full			(commit_full),
		.issue_no		(next_no),
		.issue			(issue_strobe),
		.rd				(u_rd_if.dispatch),
		.out_valid		(out_valid),
		.out_instr		(out_instr),
		.out_issue_no	(out_issue_no),
		.out_last		(out_last),
		.credit_return	(credit_return)
	);

	commit_tracker u_commit (
		.clock			(clock),
		.rst			(rst),
		.issue			(issue_strobe),
		.next_no		(next_no),
		.commit_valid	(commit_valid),
		.commit_no		(commit_no),
		.commit_err		(commit_err),
		.full			(commit_full)
	);

endmodule

//--- logic/thread_loader.sv
`timescale 1ns/1ps

module thread_loader (
	input	logic				clock,
	input	logic				rst,
	input	logic				load_valid,
	input	mpu_pkg::instr_t	load_data,
	output	logic				load_err,
	thread_wr_if.loader			wr
);

	mpu_pkg::loader_state_e		state;
	mpu_pkg::len_t				alloc_ptr;		// Bump pointer, reaches MEM_DEPTH when full
	mpu_pkg::len_t				remain;			// Words left in body or skip
	mpu_pkg::id_t				cur_id;
	mpu_pkg::addr_t				cur_base;
	mpu_pkg::len_t				cur_len;

	mpu_pkg::id_t				hdr_id;
	mpu_pkg::len_t				hdr_len;
	logic [7:0]					hdr_end;
	logic						hdr_take;
	logic						hdr_bad;
	logic						body_take;
	logic						last_word;

	//////////////////////////////////////////////////
	// Header decode
	assign hdr_id    = load_data[mpu_pkg::HDR_ID_LSB +: $bits(mpu_pkg::id_t)];
	assign hdr_len   = load_data[mpu_pkg::HDR_LEN_LSB +: $bits(mpu_pkg::len_t)];
	assign hdr_end   = {1'b0, alloc_ptr} + {1'b0, hdr_len};
	assign hdr_take  = (state == mpu_pkg::HEADER) && load_valid;
	assign hdr_bad   = (hdr_len == '0) || (hdr_end > 8'(mpu_pkg::MEM_DEPTH));
	assign body_take = (state == mpu_pkg::BODY) && load_valid;
	assign last_word = (remain == 7'd1);

	// Body words go straight to memory
	assign wr.instr_we   = body_take;
	assign wr.instr_addr = mpu_pkg::addr_t'(alloc_ptr);
	assign wr.instr_data = load_data;

	// Map entry lands with the last body word
	assign wr.map_we    = body_take && last_word;
	assign wr.map_id    = cur_id;
	assign wr.map_entry = '{valid: 1'b1, base: cur_base, len: cur_len};

	//////////////////////////////////////////////////
	// Stream FSM
	always_ff @(posedge clock) begin
		if (rst) begin
			state     <= mpu_pkg::HEADER;
			alloc_ptr <= '0;
			remain    <= '0;
			load_err  <= 1'b0;
		end else begin
			load_err <= hdr_take && hdr_bad;
			case (state)
				mpu_pkg::HEADER: if (load_valid) begin
					remain <= hdr_len;
					if (hdr_len == '0)
						state <= mpu_pkg::HEADER;	// Nothing to skip
					else if (hdr_bad)
						state <= mpu_pkg::SKIP;
					else
						state <= mpu_pkg::BODY;
				end
				mpu_pkg::BODY: if (load_valid) begin
					alloc_ptr <= alloc_ptr + 1'b1;
					remain    <= remain - 1'b1;
					if (last_word)
						state <= mpu_pkg::HEADER;
				end
				mpu_pkg::SKIP: if (load_valid) begin
					remain <= remain - 1'b1;
					if (last_word)
						state <= mpu_pkg::HEADER;
				end
				default: state <= mpu_pkg::HEADER;
			endcase
		end
	end

	// Thread being written
	always_ff @(posedge clock) begin
		if (hdr_take) begin
			cur_id   <= hdr_id;
			cur_base <= mpu_pkg::addr_t'(alloc_ptr);
			cur_len  <= hdr_len;
		end
	end

	// Writes stay inside the space granted at the header
	a_wr_in_bounds: assert property (@(posedge clock) disable iff (rst)
		wr.instr_we |-> ({1'b0, wr.instr_addr} < ({1'b0, cur_base} + cur_len)));

endmodule

//--- logic/thread_mem.sv
`timescale 1ns/1ps

module thread_mem (
	input	logic			clock,
	input	logic			rst,
	thread_wr_if.mem		wr,
	thread_rd_if.mem		rd
);

	mpu_pkg::instr_t					instr_ram [mpu_pkg::MEM_DEPTH];

	// Map table, valid bits kept apart from base and length
	logic [mpu_pkg::THREAD_NUM-1:0]		map_valid;
	mpu_pkg::addr_t						map_base [mpu_pkg::THREAD_NUM];
	mpu_pkg::len_t						map_len  [mpu_pkg::THREAD_NUM];

	//////////////////////////////////////////////////
	// Instruction storage
	always_ff @(posedge clock) begin
		if (wr.instr_we) begin
			instr_ram[wr.instr_addr] <= wr.instr_data;
		end
	end

	// Registered read port
	always_ff @(posedge clock) begin
		if (rd.rd_en) begin
			rd.rd_data <= instr_ram[rd.rd_addr];
		end
	end

	//////////////////////////////////////////////////
	// Map table
	always_ff @(posedge clock) begin
		if (rst) begin
			map_valid <= '0;
		end else if (wr.map_we) begin
			map_valid[wr.map_id] <= wr.map_entry.valid;
		end
	end

	// Reload just overwrites the entry
	always_ff @(posedge clock) begin
		if (wr.map_we) begin
			map_base[wr.map_id] <= wr.map_entry.base;
			map_len[wr.map_id]  <= wr.map_entry.len;
		end
	end

	// Combinational lookup
	assign rd.lookup_entry = '{
		valid: map_valid[rd.lookup_id],
		base:  map_base[rd.lookup_id],
		len:   map_len[rd.lookup_id]
	};

endmodule

//--- logic/thread_rd_if.sv
`timescale 1ns/1ps

interface thread_rd_if;

	// Map lookup, answered in the same cycle
	mpu_pkg::id_t        lookup_id;
	mpu_pkg::map_entry_t lookup_entry;

	// Instruction read, data on the next edge
	logic                rd_en;
	mpu_pkg::addr_t      rd_addr;
	mpu_pkg::instr_t     rd_data;

	modport dispatch (output lookup_id, rd_en, rd_addr, input  lookup_entry, rd_data);
	modport mem      (input  lookup_id, rd_en, rd_addr, output lookup_entry, rd_data);

endinterface

//--- logic/thread_wr_if.sv
`timescale 1ns/1ps

interface thread_wr_if;

	// Instruction write, one word per cycle
	logic                instr_we;
	mpu_pkg::addr_t      instr_addr;
	mpu_pkg::instr_t     instr_data;

	// Map table update
	logic                map_we;
	mpu_pkg::id_t        map_id;
	mpu_pkg::map_entry_t map_entry;

	modport loader (output instr_we, instr_addr, instr_data, map_we, map_id, map_entry);
	modport mem    (input  instr_we, instr_addr, instr_data, map_we, map_id, map_entry);

endinterface

//--- project.f
+incdir+dv
logic/mpu_pkg.sv
logic/thread_wr_if.sv
logic/thread_rd_if.sv
logic/thread_loader.sv
logic/thread_mem.sv
logic/dispatch_fsm.sv
logic/commit_tracker.sv
logic/mpu_top.sv
dv/mpu_tb.sv
